//--- Makefile
# Verilator build and run for the IPv4 receive parser testbench

VERILATOR ?= verilator
TOP       ?= ip_eth_rx_tb
FILELIST  ?= ip_eth_rx.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- include/ip_rx_config.svh
// Configuration macros for the IPv4 receive parser
//   stream byte width and fixed header size
//   expected version, IHL and folded checksum values
`ifndef IP_RX_CONFIG_SVH
`define IP_RX_CONFIG_SVH

// payload stream byte width
`define IP_DATA_W 8

// header without options, five 32-bit words
`define IP_HDR_BYTES 20

// only plain IPv4 with a 5-word header is accepted
`define IP_VERSION_V4 4'd4
`define IP_IHL_MIN 4'd5

// sum over all header halfwords, checksum field included,
// folds to all ones when the header is intact
`define IP_CSUM_GOOD 16'hffff

`endif

//--- ip_eth_rx.f
+incdir+include
verilog/ip_hdr_pkg.sv
verilog/ip_rx_state_pkg.sv
verilog/ip_hdr_parser.sv
verilog/ip_payload_fwd.sv
verilog/ip_rx_seq.sv
verilog/ip_eth_rx.sv
verif/ip_eth_rx_tb.sv

//--- include/ip_eth_rx_tb_cases.svh
// Stimulus table for the IPv4 receive testbench
//   header fields, bytes sent with the header included,
//   header corruption, tuser on the final input beat, expected error
`ifndef IP_ETH_RX_TB_CASES_SVH
`define IP_ETH_RX_TB_CASES_SVH

localparam int NUM_CASES = 14;

// ver, ihl, len, ttl, proto, src, dst, sent, corrupt, tuser, err
case_t cases [NUM_CASES] = '{
    // short good frame, then a long one under back-pressure
    '{4'd4, 4'd5, 16'd28, 8'd64, 8'h11, 32'hc0a80001, 32'hc0a80002, 16'd28, C_NONE, 1'b0, E_NONE},
    '{4'd4, 4'd5, 16'd84, 8'd128, 8'h06, 32'h0a000001, 32'h0a0000fe, 16'd84, C_NONE, 1'b0, E_NONE},
    // rejected headers, each followed by a good frame
    '{4'd4, 4'd5, 16'd40, 8'd32, 8'h11, 32'hac100a01, 32'hac100a02, 16'd40, C_VER, 1'b0, E_BAD_HDR},
    '{4'd4, 4'd5, 16'd30, 8'd255, 8'h01, 32'h7f000001, 32'h7f000002, 16'd30, C_NONE, 1'b0, E_NONE},
    '{4'd4, 4'd5, 16'd36, 8'd64, 8'h06, 32'h01020304, 32'h05060708, 16'd36, C_CSUM, 1'b0, E_BAD_CSUM},
    '{4'd4, 4'd6, 16'd36, 8'd64, 8'h11, 32'hc0a80101, 32'hc0a80102, 16'd36, C_NONE, 1'b0, E_BAD_HDR},
    '{4'd4, 4'd5, 16'd48, 8'd64, 8'h11, 32'hdeadbeef, 32'h12345678, 16'd48, C_NONE, 1'b0, E_NONE},
    // frame ends inside the header
    '{4'd4, 4'd5, 16'd40, 8'd64, 8'h11, 32'hc0a80001, 32'hc0a80003, 16'd12, C_NONE, 1'b0, E_HDR_EARLY},
    // payload shorter than the length field
    '{4'd4, 4'd5, 16'd50, 8'd20, 8'h06, 32'h0a0a0a0a, 32'h0b0b0b0b, 16'd35, C_NONE, 1'b0, E_PAY_EARLY},
    // payload longer than the length field, trailing bytes dropped
    '{4'd4, 4'd5, 16'd32, 8'd20, 8'h06, 32'hc0000201, 32'hc0000202, 16'd45, C_NONE, 1'b1, E_NONE},
    '{4'd4, 4'd5, 16'd25, 8'd1, 8'h11, 32'h08080808, 32'h08080404, 16'd25, C_NONE, 1'b1, E_NONE},
    '{4'd4, 4'd5, 16'd21, 8'd9, 8'h11, 32'h64400001, 32'h64400002, 16'd21, C_NONE, 1'b0, E_NONE},
    '{4'd4, 4'd5, 16'd24, 8'd64, 8'h11, 32'hffffffff, 32'h00000000, 16'd40, C_NONE, 1'b0, E_NONE},
    '{4'd4, 4'd5, 16'd120, 8'd64, 8'h11, 32'ha9fe0001, 32'ha9fe00ff, 16'd120, C_NONE, 1'b0, E_NONE}
};

`endif

//--- verif/ip_eth_rx_tb.sv
// Testbench for the IPv4 receive parser
//   clock, reset, LCG payload bytes and output back-pressure
//   frame builder with its own header checksum, frame driver
//   output monitor, per-case checks and summary
`timescale 1ns/1ps

module ip_eth_rx_tb;

    typedef enum logic [1:0] {C_NONE, C_VER, C_CSUM} corrupt_e;
    typedef enum logic [2:0] {E_NONE, E_HDR_EARLY, E_PAY_EARLY, E_BAD_HDR, E_BAD_CSUM} err_e;

    typedef struct packed {
        logic [3:0]  ver;
        logic [3:0]  ihl;
        logic [15:0] len;
        logic [7:0]  ttl;
        logic [7:0]  proto;
        logic [31:0] src;
        logic [31:0] dst;
        logic [15:0] sent;
        corrupt_e    corrupt;
        logic        tuser;
        err_e        err;
    } case_t;

    `include "ip_eth_rx_tb_cases.svh"

    localparam int WAIT_LIMIT = 2000;
    localparam logic [31:0] SEED = 32'hdda8_6e9b;

    logic clk = 1'b0;
    logic rst;
    logic eth_hdr_valid, eth_hdr_ready;
    logic [7:0] in_tdata;
    logic in_tvalid, in_tready, in_tlast, in_tuser;
    logic ip_hdr_valid, ip_hdr_ready;
    logic [3:0] ip_version, ip_ihl;
    logic [15:0] ip_length;
    logic [7:0] ip_ttl, ip_protocol;
    logic [31:0] ip_source_ip, ip_dest_ip;
    logic [7:0] out_tdata;
    logic out_tvalid, out_tlast, out_tuser;
    logic out_tready = 1'b0;
    logic busy;
    logic error_header_early_termination, error_payload_early_termination;
    logic error_invalid_header, error_invalid_checksum;

    logic [31:0] rng;
    logic [31:0] rdy_rng = SEED;
    logic [7:0] frame[$];
    logic [9:0] got_beats[$];
    logic [31:0] hdr_got [7];
    int hdr_seen = 0;
    int err_cnt [4] = '{default: 0};
    int data_base;
    int hdr_base;
    int err_base [4];
    int errors;
    bit timed_out;

    string field_name [7] = '{"ip_version", "ip_ihl", "ip_length", "ip_ttl", "ip_protocol",
                              "ip_source_ip", "ip_dest_ip"};
    string err_name [4] = '{"error_header_early_termination", "error_payload_early_termination",
                            "error_invalid_header", "error_invalid_checksum"};

    ip_eth_rx uut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // random back-pressure, about three cycles in four ready
    always @(posedge clk) begin
        rdy_rng <= lcg_next(rdy_rng);
        out_tready <= !rst && (rdy_rng[31:30] != 2'b00);
    end

    // sampled mid-cycle, where every DUT output is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (out_tvalid && out_tready) begin
                got_beats.push_back({out_tuser, out_tlast, out_tdata});
            end
            if (ip_hdr_valid && ip_hdr_ready) begin
                hdr_seen++;
                hdr_got = '{32'(ip_version), 32'(ip_ihl), 32'(ip_length), 32'(ip_ttl),
                            32'(ip_protocol), ip_source_ip, ip_dest_ip};
            end
            err_cnt[0] += int'(error_header_early_termination);
            err_cnt[1] += int'(error_payload_early_termination);
            err_cnt[2] += int'(error_invalid_header);
            err_cnt[3] += int'(error_invalid_checksum);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // poll eth_hdr_ready or in_tready on falling edges
    task automatic wait_ready(input bit use_in, input string what);
        int t;
        t = 0;
        @(negedge clk);
        while (!(use_in ? in_tready : eth_hdr_ready) && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        assert (use_in ? in_tready : eth_hdr_ready) else begin
            $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // header with a correct checksum unless corrupted, then random payload
    task automatic build_frame(input case_t c);
        logic [7:0] hdr [20];
        logic [31:0] sum;
        logic [15:0] csum;
        int i;
        rng = lcg_next(rng);
        hdr[0] = {(c.corrupt == C_VER) ? 4'd6 : c.ver, c.ihl};
        hdr[1] = 8'h00;
        hdr[2] = c.len[15:8];
        hdr[3] = c.len[7:0];
        hdr[4] = rng[31:24];
        hdr[5] = rng[23:16];
        hdr[6] = 8'h40;
        hdr[7] = 8'h00;
        hdr[8] = c.ttl;
        hdr[9] = c.proto;
        hdr[10] = 8'h00;
        hdr[11] = 8'h00;
        for (i = 0; i < 4; i++) begin
            hdr[12 + i] = c.src[31 - 8 * i -: 8];
            hdr[16 + i] = c.dst[31 - 8 * i -: 8];
        end
        sum = 32'd0;
        for (i = 0; i < 20; i += 2) begin
            sum = sum + {16'd0, hdr[i], hdr[i + 1]};
        end
        while (sum[31:16] != 16'd0) begin
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        end
        csum = ~sum[15:0];
        if (c.corrupt == C_CSUM) begin
            csum = csum ^ 16'h0001;
        end
        hdr[10] = csum[15:8];
        hdr[11] = csum[7:0];
        frame.delete();
        for (i = 0; i < int'(c.sent); i++) begin
            rng = lcg_next(rng);
            frame.push_back((i < 20) ? hdr[i] : rng[31:24]);
        end
    endtask

    task automatic send_frame(input logic tuser);
        int i;
        @(posedge clk);
        eth_hdr_valid <= 1'b1;
        wait_ready(1'b0, "eth_hdr_ready at frame start");
        @(posedge clk);
        eth_hdr_valid <= 1'b0;
        for (i = 0; i < frame.size() && !timed_out; i++) begin
            in_tvalid <= 1'b1;
            in_tdata <= frame[i];
            in_tlast <= (i == frame.size() - 1);
            in_tuser <= tuser && (i == frame.size() - 1);
            wait_ready(1'b1, "in_tready");
            // the frame was taken one cycle ago
            if (i == 0) begin
                check_value("busy", 32'(busy), 32'd1);
            end
            @(posedge clk);
        end
        in_tvalid <= 1'b0;
        in_tlast <= 1'b0;
        in_tuser <= 1'b0;
    endtask

    // expected output follows the header verdict, the length field and the bytes sent
    task automatic check_case(input case_t c);
        logic [31:0] exp_f [7];
        logic [9:0] beat;
        bit hdr_exp;
        int sent;
        int len;
        int n_out;
        int n_got;
        int i;
        sent = int'(c.sent);
        len = int'(c.len);
        hdr_exp = (c.err == E_NONE) || (c.err == E_PAY_EARLY);
        n_out = hdr_exp ? ((sent < len) ? sent : len) - 20 : 0;
        n_got = got_beats.size() - data_base;
        check_true(hdr_seen - hdr_base == (hdr_exp ? 1 : 0),
                   $sformatf("header presented %0d times, expected %0d",
                             hdr_seen - hdr_base, hdr_exp));
        exp_f = '{32'(c.ver), 32'(c.ihl), 32'(c.len), 32'(c.ttl), 32'(c.proto), c.src, c.dst};
        if (hdr_exp && hdr_seen > hdr_base) begin
            for (i = 0; i < 7; i++) begin
                check_value(field_name[i], hdr_got[i], exp_f[i]);
            end
        end
        check_true(n_got == n_out, $sformatf("%0d payload bytes out, expected %0d", n_got, n_out));
        for (i = 0; i < n_out && i < n_got; i++) begin
            beat = got_beats[data_base + i];
            check_value("out_tdata", 32'(beat[7:0]), 32'(frame[20 + i]));
            check_value("out_tlast", 32'(beat[8]), 32'(i == n_out - 1));
            check_value("out_tuser", 32'(beat[9]),
                        32'((i == n_out - 1) && ((sent < len) || c.tuser)));
        end
        for (i = 0; i < 4; i++) begin
            check_true(err_cnt[i] - err_base[i] == ((int'(c.err) == i + 1) ? 1 : 0),
                       $sformatf("%s pulsed %0d times, expected %0d", err_name[i],
                                 err_cnt[i] - err_base[i], int'(c.err) == i + 1));
        end
    endtask

    initial begin
        int k;
        int first;
        rst = 1'b1;
        eth_hdr_valid = 1'b0;
        in_tdata = 8'h00;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        ip_hdr_ready = 1'b0;
        errors = 0;
        timed_out = 1'b0;
        rng = SEED;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        ip_hdr_ready <= 1'b1;
        for (k = 0; k < NUM_CASES && !timed_out; k++) begin
            first = errors;
            data_base = got_beats.size();
            hdr_base = hdr_seen;
            err_base = err_cnt;
            build_frame(cases[k]);
            send_frame(cases[k].tuser);
            wait_ready(1'b0, "end of frame");
            check_value("busy", 32'(busy), 32'd0);
            @(posedge clk);
            check_case(cases[k]);
            $display("case %0d: %s", k, (errors == first) ? "ok" : "failed");
        end
        $display("%0d of %0d cases run, %0d errors", k, NUM_CASES, errors);
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verilog/ip_eth_rx.sv
// IPv4 receive parser top level
//   frame sequencer, header parser and payload forwarder
`timescale 1ns/1ps

module ip_eth_rx (
    input  logic                   clk,
    input  logic                   rst,
    // start of frame from the Ethernet decoder
    input  logic                   eth_hdr_valid,
    output logic                   eth_hdr_ready,
    // Ethernet payload stream
    input  ip_hdr_pkg::ip_byte_t   in_tdata,
    input  logic                   in_tvalid,
    output logic                   in_tready,
    input  logic                   in_tlast,
    input  logic                   in_tuser,
    // decoded header
    output logic                   ip_hdr_valid,
    input  logic                   ip_hdr_ready,
    output ip_hdr_pkg::ip_nibble_t ip_version,
    output ip_hdr_pkg::ip_nibble_t ip_ihl,
    output ip_hdr_pkg::ip_word16_t ip_length,
    output ip_hdr_pkg::ip_byte_t   ip_ttl,
    output ip_hdr_pkg::ip_byte_t   ip_protocol,
    output ip_hdr_pkg::ip_addr_t   ip_source_ip,
    output ip_hdr_pkg::ip_addr_t   ip_dest_ip,
    // IP payload stream
    output ip_hdr_pkg::ip_byte_t   out_tdata,
    output logic                   out_tvalid,
    input  logic                   out_tready,
    output logic                   out_tlast,
    output logic                   out_tuser,
    // status
    output logic                   busy,
    output logic                   error_header_early_termination,
    output logic                   error_payload_early_termination,
    output logic                   error_invalid_header,
    output logic                   error_invalid_checksum
);

    logic hdr_beat;
    logic pay_beat;
    logic hdr_done;
    logic hdr_ok;
    logic pay_ready;
    logic pay_done;

    ip_rx_seq u_seq (
        .clk                            (clk),
        .rst                            (rst),
        .eth_hdr_valid                  (eth_hdr_valid),
        .in_tvalid                      (in_tvalid),
        .in_tlast                       (in_tlast),
        .hdr_done                       (hdr_done),
        .hdr_ok                         (hdr_ok),
        .pay_ready                      (pay_ready),
        .pay_done                       (pay_done),
        .ip_hdr_ready                   (ip_hdr_ready),
        .eth_hdr_ready                  (eth_hdr_ready),
        .in_tready                      (in_tready),
        .hdr_beat                       (hdr_beat),
        .pay_beat                       (pay_beat),
        .ip_hdr_valid                   (ip_hdr_valid),
        .busy                           (busy),
        .error_header_early_termination (error_header_early_termination)
    );

    ip_hdr_parser u_parser (
        .clk                    (clk),
        .rst                    (rst),
        .hdr_beat               (hdr_beat),
        .in_tdata               (in_tdata),
        .in_tlast               (in_tlast),
        .hdr_done               (hdr_done),
        .hdr_ok                 (hdr_ok),
        .ip_version             (ip_version),
        .ip_ihl                 (ip_ihl),
        .ip_length              (ip_length),
        .ip_ttl                 (ip_ttl),
        .ip_protocol            (ip_protocol),
        .ip_source_ip           (ip_source_ip),
        .ip_dest_ip             (ip_dest_ip),
        .error_invalid_header   (error_invalid_header),
        .error_invalid_checksum (error_invalid_checksum)
    );

    ip_payload_fwd u_fwd (
        .clk                             (clk),
        .rst                             (rst),
        .pay_beat                        (pay_beat),
        .in_tdata                        (in_tdata),
        .in_tlast                        (in_tlast),
        .in_tuser                        (in_tuser),
        .ip_length                       (ip_length),
        .out_tready                      (out_tready),
        .pay_ready                       (pay_ready),
        .pay_done                        (pay_done),
        .out_tdata                       (out_tdata),
        .out_tvalid                      (out_tvalid),
        .out_tlast                       (out_tlast),
        .out_tuser                       (out_tuser),
        .error_payload_early_termination (error_payload_early_termination)
    );

endmodule

//--- verilog/ip_hdr_parser.sv
// IPv4 header parser
//   byte offset counter and field capture registers
//   ones' complement header sum with end-around carry
//   version, IHL and checksum verdict on the last header byte
`timescale 1ns/1ps
`include "ip_rx_config.svh"

module ip_hdr_parser (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hdr_beat,
    input  ip_hdr_pkg::ip_byte_t   in_tdata,
    input  logic                   in_tlast,
    output logic                   hdr_done,
    output logic                   hdr_ok,
    output ip_hdr_pkg::ip_nibble_t ip_version,
    output ip_hdr_pkg::ip_nibble_t ip_ihl,
    output ip_hdr_pkg::ip_word16_t ip_length,
    output ip_hdr_pkg::ip_byte_t   ip_ttl,
    output ip_hdr_pkg::ip_byte_t   ip_protocol,
    output ip_hdr_pkg::ip_addr_t   ip_source_ip,
    output ip_hdr_pkg::ip_addr_t   ip_dest_ip,
    output logic                   error_invalid_header,
    output logic                   error_invalid_checksum
);
    import ip_hdr_pkg::*;

    ip_hdr_off_e off_q;
    ip_word16_t  sum_q;
    ip_word16_t  sum_next;
    logic        vi_ok;
    logic        csum_ok;

    function automatic ip_word16_t ones_add(input ip_word16_t a, input ip_word16_t b);
        logic [16:0] t;
        t = {1'b0, a} + {1'b0, b};
        return t[15:0] + {15'd0, t[16]};
    endfunction

    // even offsets are the high byte of a halfword
    assign sum_next = off_q[0] ? ones_add(sum_q, {8'h00, in_tdata})
                               : ones_add(sum_q, {in_tdata, 8'h00});

    // version and IHL were captured on the first byte of this header
    assign vi_ok    = (ip_version == `IP_VERSION_V4) && (ip_ihl == `IP_IHL_MIN);
    assign csum_ok  = (sum_next == `IP_CSUM_GOOD);
    assign hdr_done = hdr_beat && (off_q == OFF_DST3);
    assign hdr_ok   = vi_ok && csum_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            off_q <= OFF_VER_IHL;
            sum_q <= '0;
            error_invalid_header <= 1'b0;
            error_invalid_checksum <= 1'b0;
        end else begin
            if (hdr_beat) begin
                if (hdr_done || in_tlast) begin
                    off_q <= OFF_VER_IHL;
                    sum_q <= '0;
                end else begin
                    off_q <= ip_hdr_off_e'(off_q + 5'd1);
                    sum_q <= sum_next;
                end
            end
            // a header cut short is reported by the sequencer instead
            error_invalid_header <= hdr_done && !in_tlast && !vi_ok;
            error_invalid_checksum <= hdr_done && !in_tlast && vi_ok && !csum_ok;
        end
    end

    // bytes not listed are only summed
    always_ff @(posedge clk) begin
        if (hdr_beat) begin
            case (off_q)
                OFF_VER_IHL: {ip_version, ip_ihl} <= in_tdata;
                OFF_LEN_HI:  ip_length[15:8] <= in_tdata;
                OFF_LEN_LO:  ip_length[7:0] <= in_tdata;
                OFF_TTL:     ip_ttl <= in_tdata;
                OFF_PROTO:   ip_protocol <= in_tdata;
                OFF_SRC0:    ip_source_ip[31:24] <= in_tdata;
                OFF_SRC1:    ip_source_ip[23:16] <= in_tdata;
                OFF_SRC2:    ip_source_ip[15:8] <= in_tdata;
                OFF_SRC3:    ip_source_ip[7:0] <= in_tdata;
                OFF_DST0:    ip_dest_ip[31:24] <= in_tdata;
                OFF_DST1:    ip_dest_ip[23:16] <= in_tdata;
                OFF_DST2:    ip_dest_ip[15:8] <= in_tdata;
                OFF_DST3:    ip_dest_ip[7:0] <= in_tdata;
                default: begin
                end
            endcase
        end
    end

endmodule

//--- verilog/ip_hdr_pkg.sv
// IPv4 header description
//   field types used on the parser and top level ports
//   byte offset enum for the fixed 20-byte header
`include "ip_rx_config.svh"

package ip_hdr_pkg;

    typedef logic [`IP_DATA_W-1:0] ip_byte_t;
    typedef logic [15:0] ip_word16_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [3:0] ip_nibble_t;

    // byte positions in network order
    typedef enum logic [4:0] {
        OFF_VER_IHL  = 5'd0,
        OFF_DSCP_ECN = 5'd1,
        OFF_LEN_HI   = 5'd2,
        OFF_LEN_LO   = 5'd3,
        OFF_ID_HI    = 5'd4,
        OFF_ID_LO    = 5'd5,
        OFF_FRAG_HI  = 5'd6,
        OFF_FRAG_LO  = 5'd7,
        OFF_TTL      = 5'd8,
        OFF_PROTO    = 5'd9,
        OFF_CSUM_HI  = 5'd10,
        OFF_CSUM_LO  = 5'd11,
        OFF_SRC0     = 5'd12,
        OFF_SRC1     = 5'd13,
        OFF_SRC2     = 5'd14,
        OFF_SRC3     = 5'd15,
        OFF_DST0     = 5'd16,
        OFF_DST1     = 5'd17,
        OFF_DST2     = 5'd18,
        OFF_DST3     = 5'd19
    } ip_hdr_off_e;

endpackage

//--- verilog/ip_payload_fwd.sv
// IP payload forwarder
//   output register with one skid slot
//   byte counter against the total length field
//   early termination, trim to length and trailing discard
`timescale 1ns/1ps
`include "ip_rx_config.svh"

module ip_payload_fwd (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pay_beat,
    input  ip_hdr_pkg::ip_byte_t   in_tdata,
    input  logic                   in_tlast,
    input  logic                   in_tuser,
    input  ip_hdr_pkg::ip_word16_t ip_length,
    input  logic                   out_tready,
    output logic                   pay_ready,
    output logic                   pay_done,
    output ip_hdr_pkg::ip_byte_t   out_tdata,
    output logic                   out_tvalid,
    output logic                   out_tlast,
    output logic                   out_tuser,
    output logic                   error_payload_early_termination
);
    import ip_hdr_pkg::*;
    import ip_rx_state_pkg::*;

    pay_state_e state_q;
    pay_state_e state_d;
    pay_state_e beat_state;
    pay_state_e skid_state_q;
    ip_word16_t ptr_q;
    ip_word16_t ptr_next;
    ip_byte_t   skid_data_q;
    logic       skid_last_q;
    logic       skid_user_q;
    logic       hit_len;
    logic       early;
    logic       load_out;
    logic       load_skid;
    logic       drain_skid;

    // ptr counts bytes of the whole datagram, header included
    assign ptr_next = ptr_q + 16'd1;
    assign hit_len  = (ptr_next == ip_length);
    assign early    = in_tlast && !hit_len;

    // where an incoming byte leaves the output register
    assign beat_state = in_tlast ? LAST : (hit_len ? TRIM : FULL);

    assign pay_ready  = (state_q == EMPTY) || (state_q == FULL) || (state_q == TRIM);
    assign out_tvalid = (state_q == FULL) || (state_q == SKID) || (state_q == LAST);
    assign pay_done   = (state_q == LAST) && out_tready;

    always_comb begin
        state_d = state_q;
        load_out = 1'b0;
        load_skid = 1'b0;
        drain_skid = 1'b0;
        case (state_q)
            EMPTY: begin
                if (pay_beat) begin
                    load_out = 1'b1;
                    state_d = beat_state;
                end
            end
            FULL: begin
                if (pay_beat && out_tready) begin
                    load_out = 1'b1;
                    state_d = beat_state;
                end else if (pay_beat) begin
                    load_skid = 1'b1;
                    state_d = SKID;
                end else if (out_tready) begin
                    state_d = EMPTY;
                end
            end
            SKID: begin
                if (out_tready) begin
                    drain_skid = 1'b1;
                    state_d = skid_state_q;
                end
            end
            LAST: begin
                if (out_tready) state_d = EMPTY;
            end
            // byte at the length is held back until the input frame ends
            TRIM: begin
                if (pay_beat && in_tlast) state_d = LAST;
            end
            default: state_d = EMPTY;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= EMPTY;
            ptr_q <= 16'(`IP_HDR_BYTES);
            error_payload_early_termination <= 1'b0;
        end else begin
            state_q <= state_d;
            if (pay_done) begin
                ptr_q <= 16'(`IP_HDR_BYTES);
            end else if (pay_beat && state_q != TRIM) begin
                ptr_q <= ptr_next;
            end
            error_payload_early_termination <= pay_beat && early && (state_q != TRIM);
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_tdata <= in_tdata;
            out_tlast <= in_tlast || hit_len;
            out_tuser <= in_tuser || early;
        end else if (drain_skid) begin
            out_tdata <= skid_data_q;
            out_tlast <= skid_last_q;
            out_tuser <= skid_user_q;
        end else if (state_q == TRIM && pay_beat && in_tlast) begin
            out_tuser <= out_tuser || in_tuser;
        end
        if (load_skid) begin
            skid_data_q <= in_tdata;
            skid_last_q <= in_tlast || hit_len;
            skid_user_q <= in_tuser || early;
            skid_state_q <= beat_state;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> $stable(out_tdata));

endmodule

//--- verilog/ip_rx_seq.sv
// Frame sequencer for the IPv4 receive path
//   idle, header, payload and discard states
//   input ready, header valid hold, busy flag
//   header early termination pulse
`timescale 1ns/1ps

module ip_rx_seq (
    input  logic clk,
    input  logic rst,
    input  logic eth_hdr_valid,
    input  logic in_tvalid,
    input  logic in_tlast,
    input  logic hdr_done,
    input  logic hdr_ok,
    input  logic pay_ready,
    input  logic pay_done,
    input  logic ip_hdr_ready,
    output logic eth_hdr_ready,
    output logic in_tready,
    output logic hdr_beat,
    output logic pay_beat,
    output logic ip_hdr_valid,
    output logic busy,
    output logic error_header_early_termination
);
    import ip_rx_state_pkg::*;

    rx_state_e state_q;
    rx_state_e state_d;
    logic      hdr_valid_d;
    logic      hdr_early_d;

    assign in_tready = (state_q == HEADER) || (state_q == DISCARD) ||
                       ((state_q == PAYLOAD) && pay_ready);
    assign hdr_beat  = (state_q == HEADER) && in_tvalid;
    assign pay_beat  = (state_q == PAYLOAD) && in_tvalid && pay_ready;

    always_comb begin
        state_d = state_q;
        hdr_valid_d = ip_hdr_valid && !ip_hdr_ready;
        hdr_early_d = 1'b0;
        case (state_q)
            IDLE: begin
                if (eth_hdr_valid && eth_hdr_ready) state_d = HEADER;
            end
            HEADER: begin
                if (hdr_beat && in_tlast) begin
                    hdr_early_d = 1'b1;
                    state_d = IDLE;
                end else if (hdr_done && hdr_ok) begin
                    hdr_valid_d = 1'b1;
                    state_d = PAYLOAD;
                end else if (hdr_done) begin
                    state_d = DISCARD;
                end
            end
            PAYLOAD: begin
                if (pay_done) state_d = IDLE;
            end
            // drop the rest of a rejected frame
            DISCARD: begin
                if (in_tvalid && in_tlast) state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            ip_hdr_valid <= 1'b0;
            eth_hdr_ready <= 1'b0;
            busy <= 1'b0;
            error_header_early_termination <= 1'b0;
        end else begin
            state_q <= state_d;
            ip_hdr_valid <= hdr_valid_d;
            // next frame waits until the current header is taken
            eth_hdr_ready <= (state_d == IDLE) && !hdr_valid_d;
            busy <= (state_d != IDLE);
            error_header_early_termination <= hdr_early_d;
        end
    end

    // a frame is never taken while the previous header is still offered
    a_hdr_clear_in_header: assert property (@(posedge clk) disable iff (rst)
        (state_q == HEADER) |-> !ip_hdr_valid);

endmodule

//--- verilog/ip_rx_state_pkg.sv
// Receiver control description
//   frame sequencer states
//   payload output register states
package ip_rx_state_pkg;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        HEADER  = 2'd1,
        PAYLOAD = 2'd2,
        DISCARD = 2'd3
    } rx_state_e;

    // EMPTY and TRIM hold no valid output byte
    typedef enum logic [2:0] {
        EMPTY = 3'd0,
        FULL  = 3'd1,
        SKID  = 3'd2,
        LAST  = 3'd3,
        TRIM  = 3'd4
    } pay_state_e;

endpackage
